// File: common/keypad_pkg.sv
package keypad_pkg;

    // scan timing, in clock cycles
    localparam int scan_interval = 64;
    localparam int col_settle = 3;

    // identical frames needed before a key state is accepted
    localparam int debounce_frames = 3;

    localparam int scan_cnt_w = $clog2(scan_interval);
    localparam int settle_cnt_w = $clog2(col_settle);

    // value is row * 4 + column
    typedef enum logic [3:0] {
        KEY_1    = 4'd0,
        KEY_2    = 4'd1,
        KEY_3    = 4'd2,
        KEY_A    = 4'd3,
        KEY_4    = 4'd4,
        KEY_5    = 4'd5,
        KEY_6    = 4'd6,
        KEY_B    = 4'd7,
        KEY_7    = 4'd8,
        KEY_8    = 4'd9,
        KEY_9    = 4'd10,
        KEY_C    = 4'd11,
        KEY_STAR = 4'd12,
        KEY_0    = 4'd13,
        KEY_HASH = 4'd14,
        KEY_D    = 4'd15
    } key_code_t;

    typedef enum logic {
        EVT_PRESS   = 1'b0,
        EVT_RELEASE = 1'b1
    } key_evt_t;

    typedef enum logic [1:0] {
        SCAN_IDLE   = 2'd0,
        SCAN_SETTLE = 2'd1,
        SCAN_SAMPLE = 2'd2,
        SCAN_DONE   = 2'd3
    } scan_state_t;

    typedef struct packed {
        logic [15:0] mask;
    } scan_frame_t;

    typedef struct packed {
        key_code_t code;
        logic      single;
        logic      empty;
    } key_loc_t;

    typedef struct packed {
        key_evt_t  kind;
        key_code_t code;
    } key_event_t;

endpackage

// File: filelist.f
common/keypad_pkg.sv
keypad/keypad_scanner.sv
keypad/key_locator.sv
keypad/stability_counter.sv
keypad/key_event_gen.sv
hdl/keypad_top.sv
test/keypad_checker.sv
test/keypad_tb.sv

// File: hdl/keypad_top.sv
`timescale 1ns/10ps

module keypad_top
    import keypad_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [3:0] row_in,
    output logic [3:0] col_out,
    output logic       event_valid,
    output key_event_t event_data
);

    logic        frame_valid;
    scan_frame_t frame;
    logic        loc_valid;
    key_loc_t    loc;
    logic        stab_valid;
    logic [2:0]  stable_count;

    keypad_scanner i_scanner (
        .clk         (clk),
        .rst_n       (rst_n),
        .row_in      (row_in),
        .col_out     (col_out),
        .frame_valid (frame_valid),
        .frame       (frame)
    );

    key_locator i_locator (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_valid (frame_valid),
        .frame       (frame),
        .loc_valid   (loc_valid),
        .loc         (loc)
    );

    // the event generator waits for both results of a frame
    stability_counter i_stab (
        .clk          (clk),
        .rst_n        (rst_n),
        .frame_valid  (frame_valid),
        .frame        (frame),
        .stab_valid   (stab_valid),
        .stable_count (stable_count)
    );

    key_event_gen i_event_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .loc_valid    (loc_valid && stab_valid),
        .loc          (loc),
        .stable_count (stable_count),
        .event_valid  (event_valid),
        .event_data   (event_data)
    );

endmodule

// File: keypad/key_event_gen.sv
`timescale 1ns/10ps

module key_event_gen
    import keypad_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       loc_valid,
    input  key_loc_t   loc,
    input  logic [2:0] stable_count,
    output logic       event_valid,
    output key_event_t event_data
);

    logic      held;
    key_code_t held_code;
    logic      stable;
    logic      do_press;
    logic      do_release;

    assign stable = loc_valid && (stable_count >= 3'(debounce_frames));

    // multi-key frames fall through both terms and leave the held key alone
    assign do_press   = stable && !held && loc.single;
    assign do_release = stable && held &&
                        (loc.empty || (loc.single && loc.code != held_code));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held        <= 1'b0;
            event_valid <= 1'b0;
        end else begin
            event_valid <= do_press || do_release;
            if (do_press) begin
                held <= 1'b1;
            end else if (do_release) begin
                // a different key gets its press on the next stable frame
                held <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_press) begin
            held_code <= loc.code;
        end
    end

    always_ff @(posedge clk) begin
        if (do_press) begin
            event_data.kind <= EVT_PRESS;
            event_data.code <= loc.code;
        end else if (do_release) begin
            event_data.kind <= EVT_RELEASE;
            event_data.code <= held_code;
        end
    end

endmodule

// File: keypad/key_locator.sv
`timescale 1ns/10ps

module key_locator
    import keypad_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        frame_valid,
    input  scan_frame_t frame,
    output logic        loc_valid,
    output key_loc_t    loc
);

    logic [4:0] ones;
    logic [3:0] idx;
    logic       single;
    logic       empty;

    // population count, idx ends on the highest set bit
    always_comb begin
        ones = '0;
        idx  = '0;
        for (int i = 0; i < 16; i++) begin
            if (frame.mask[i]) begin
                ones = ones + 5'd1;
                idx  = 4'(i);
            end
        end
    end

    // idx is only meaningful when exactly one bit is set
    assign single = (ones == 5'd1);
    assign empty  = (ones == 5'd0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            loc_valid <= 1'b0;
        end else begin
            loc_valid <= frame_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (frame_valid) begin
            loc.code   <= key_code_t'(idx);
            loc.single <= single;
            loc.empty  <= empty;
        end
    end

endmodule

// File: keypad/keypad_scanner.sv
`timescale 1ns/10ps

module keypad_scanner
    import keypad_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [3:0]  row_in,
    output logic [3:0]  col_out,
    output logic        frame_valid,
    output scan_frame_t frame
);

    scan_state_t             state;
    logic [scan_cnt_w-1:0]   interval_cnt;
    logic [settle_cnt_w-1:0] settle_cnt;
    logic [1:0]              col_idx;
    logic [15:0]             mask_q;
    logic                    frame_start;

    // free running frame timer, starts at zero when reset is released
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            interval_cnt <= '0;
        end else if (interval_cnt == scan_cnt_w'(scan_interval - 1)) begin
            interval_cnt <= '0;
        end else begin
            interval_cnt <= interval_cnt + 1'b1;
        end
    end

    assign frame_start = (interval_cnt == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= SCAN_IDLE;
            col_out    <= 4'hf;
            col_idx    <= '0;
            settle_cnt <= '0;
        end else begin
            case (state)
                SCAN_IDLE: begin
                    if (frame_start) begin
                        col_idx    <= '0;
                        settle_cnt <= '0;
                        col_out    <= 4'b1110;
                        state      <= SCAN_SETTLE;
                    end
                end
                // hold the column low while the row lines settle
                SCAN_SETTLE: begin
                    settle_cnt <= settle_cnt + 1'b1;
                    if (settle_cnt == settle_cnt_w'(col_settle - 1)) begin
                        state <= SCAN_SAMPLE;
                    end
                end
                SCAN_SAMPLE: begin
                    settle_cnt <= '0;
                    if (col_idx == 2'd3) begin
                        col_out <= 4'hf;
                        state   <= SCAN_DONE;
                    end else begin
                        col_idx <= col_idx + 2'd1;
                        col_out <= ~(4'b0001 << (col_idx + 2'd1));
                        state   <= SCAN_SETTLE;
                    end
                end
                SCAN_DONE: begin
                    state <= SCAN_IDLE;
                end
                default: begin
                    state <= SCAN_IDLE;
                end
            endcase
        end
    end

    // rows are active low, a set mask bit means pressed
    always_ff @(posedge clk) begin
        if (state == SCAN_SAMPLE) begin
            for (int r = 0; r < 4; r++) begin
                mask_q[4 * r + int'(col_idx)] <= ~row_in[r];
            end
        end
    end

    assign frame_valid = (state == SCAN_DONE);
    assign frame.mask  = mask_q;

endmodule

// File: keypad/stability_counter.sv
`timescale 1ns/10ps

module stability_counter
    import keypad_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        frame_valid,
    input  scan_frame_t frame,
    output logic        stab_valid,
    output logic [2:0]  stable_count
);

    logic [15:0] prev_mask;
    logic        changed;

    assign changed = (frame.mask != prev_mask);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stab_valid   <= 1'b0;
            stable_count <= '0;
            prev_mask    <= '0;
        end else begin
            stab_valid <= frame_valid;
            if (frame_valid) begin
                prev_mask <= frame.mask;
                if (changed) begin
                    // a new mask counts as its first frame
                    stable_count <= 3'd1;
                end else if (stable_count < 3'(debounce_frames)) begin
                    stable_count <= stable_count + 3'd1;
                end
            end
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# builds the keypad testbench with Verilator and runs it
# the exit status is zero only when the pass message shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module keypad_tb \
    -f filelist.f \
    -o keypad_sim \
    && ./obj_dir/keypad_sim | tee /dev/stderr | grep -qFx "All tests passed" \
    && echo "keypad simulation: PASS" \
    || { echo "keypad simulation: FAIL"; exit 1; }

exit 0

// File: test/keypad_checker.sv
`timescale 1ns/10ps

module keypad_checker
    import keypad_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input scan_state_t state,
    input logic [3:0]  col_out,
    input logic        frame_valid,
    input logic        event_valid
);

    int col_errors = 0;
    int idle_errors = 0;
    int frame_errors = 0;
    int event_errors = 0;
    int error_count;

    assign error_count = col_errors + idle_errors + frame_errors + event_errors;

    // one column at a time, so each key reads on one row only
    col_one_low: assert property (@(posedge clk) disable iff (!rst_n)
        $countones(~col_out) <= 1)
        else begin
            col_errors++;
            $error("more than one column driven low: %b", col_out);
        end

    col_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state == SCAN_IDLE) |-> (col_out == 4'hf))
        else begin
            idle_errors++;
            $error("column driven while the scanner is idle: %b", col_out);
        end

    frame_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        frame_valid |=> !frame_valid)
        else begin
            frame_errors++;
            $error("frame_valid held for more than one cycle");
        end

    event_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        event_valid |=> !event_valid)
        else begin
            event_errors++;
            $error("event_valid high on two consecutive cycles");
        end

endmodule

bind keypad_scanner keypad_checker i_scan_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .state       (state),
    .col_out     (col_out),
    .frame_valid (frame_valid),
    .event_valid (1'b0)
);

// the event generator has no columns, its scan inputs stay idle
bind key_event_gen keypad_checker i_evt_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .state       (SCAN_IDLE),
    .col_out     (4'hf),
    .frame_valid (1'b0),
    .event_valid (event_valid)
);

// File: test/keypad_tb.sv
`timescale 1ns/10ps

module keypad_tb
    import keypad_pkg::*;
();

    localparam int clk_period = 4;
    localparam int long_hold = debounce_frames + 2;

    typedef logic [15:0] mask_q_t[$];
    typedef int hold_q_t[$];
    typedef key_event_t event_q_t[$];

    logic       clk = 1'b0;
    logic       rst_n;
    logic [3:0] row_in;
    logic [3:0] col_out;
    logic       event_valid;
    key_event_t event_data;

    logic [15:0] key_mask;

    // steps of the test being built, moved to the step list when it closes
    mask_q_t     cur_mask;
    hold_q_t     cur_hold;
    logic [15:0] step_mask[$];
    int          step_hold[$];
    key_event_t  exp_q[$];
    string       exp_test[$];
    int          watchdog_ns = 0;

    keypad_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .row_in      (row_in),
        .col_out     (col_out),
        .event_valid (event_valid),
        .event_data  (event_data)
    );

    always #(clk_period / 2) clk = ~clk;

    // a row reads low when a pressed key on it sits on a driven column
    always_comb begin
        for (int r = 0; r < 4; r++) begin
            row_in[r] = 1'b1;
            for (int c = 0; c < 4; c++) begin
                if (key_mask[4 * r + c] && !col_out[c]) begin
                    row_in[r] = 1'b0;
                end
            end
        end
    end

    function automatic logic [15:0] key_bit(input int k);
        return 16'(1) << k;
    endfunction

    // frame by frame model of the debounce and event rules
    function automatic event_q_t expected_events(input mask_q_t masks, input hold_q_t holds);
        event_q_t    evs;
        key_event_t  ev;
        logic [15:0] prev;
        int          count;
        int          ones;
        logic        held;
        key_code_t   held_code;
        key_code_t   code;
        prev      = 16'h0000;
        count     = debounce_frames;
        held      = 1'b0;
        held_code = KEY_1;
        foreach (masks[s]) begin
            for (int f = 0; f < holds[s]; f++) begin
                if (masks[s] != prev) begin
                    count = 1;
                end else if (count < debounce_frames) begin
                    count++;
                end
                prev = masks[s];
                ones = $countones(masks[s]);
                code = KEY_1;
                for (int b = 0; b < 16; b++) begin
                    if (masks[s][b]) begin
                        code = key_code_t'(4'(b));
                    end
                end
                if (count >= debounce_frames) begin
                    if (!held && ones == 1) begin
                        ev.kind   = EVT_PRESS;
                        ev.code   = code;
                        held      = 1'b1;
                        held_code = code;
                        evs.push_back(ev);
                    end else if (held && (ones == 0 || (ones == 1 && code != held_code))) begin
                        ev.kind = EVT_RELEASE;
                        ev.code = held_code;
                        held    = 1'b0;
                        evs.push_back(ev);
                    end
                end
            end
        end
        return evs;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic compare_event(input string test_name, input key_event_t expected,
                                 input key_event_t actual);
        if (actual != expected) begin
            $display("[FAIL] %s: expected %s %s, actual %s %s", test_name,
                     expected.kind.name(), expected.code.name(),
                     actual.kind.name(), actual.code.name());
            stop_with_failure("event mismatch");
        end
    endtask

    task automatic hold_for(input logic [15:0] mask, input int frames);
        cur_mask.push_back(mask);
        cur_hold.push_back(frames);
    endtask

    task automatic end_test(input string name);
        event_q_t evs;
        evs = expected_events(cur_mask, cur_hold);
        foreach (evs[i]) begin
            exp_q.push_back(evs[i]);
            exp_test.push_back(name);
        end
        foreach (cur_mask[i]) begin
            step_mask.push_back(cur_mask[i]);
            step_hold.push_back(cur_hold[i]);
        end
        cur_mask.delete();
        cur_hold.delete();
    endtask

    task automatic build_all_keys();
        for (int k = 0; k < 16; k++) begin
            hold_for(key_bit(k), long_hold);
            hold_for(16'h0000, long_hold);
        end
        end_test("all_keys");
    endtask

    task automatic build_bounce();
        hold_for(key_bit(KEY_5), debounce_frames - 1);
        hold_for(16'h0000, 1);
        hold_for(key_bit(KEY_5), 1);
        hold_for(16'h0000, long_hold);
        hold_for(key_bit(KEY_D), debounce_frames - 1);
        hold_for(16'h0000, long_hold);
        end_test("bounce");
    endtask

    task automatic build_two_keys();
        hold_for(key_bit(KEY_1) | key_bit(KEY_5), long_hold);
        hold_for(key_bit(KEY_5), long_hold);
        hold_for(16'h0000, long_hold);
        hold_for(key_bit(KEY_2) | key_bit(KEY_C), long_hold);
        hold_for(key_bit(KEY_2), long_hold);
        hold_for(16'h0000, long_hold);
        end_test("two_keys");
    endtask

    task automatic build_slide();
        hold_for(key_bit(KEY_4), long_hold);
        hold_for(key_bit(KEY_9), long_hold);
        hold_for(16'h0000, long_hold);
        end_test("slide");
    endtask

    task automatic build_random(input int steps);
        int pick;
        int k1;
        int k2;
        for (int s = 0; s < steps; s++) begin
            pick = $urandom_range(2, 0);
            k1   = $urandom_range(15, 0);
            k2   = (k1 + $urandom_range(15, 1)) % 16;
            case (pick)
                0: hold_for(16'h0000, $urandom_range(long_hold, 1));
                1: hold_for(key_bit(k1), $urandom_range(long_hold, 1));
                default: hold_for(key_bit(k1) | key_bit(k2), $urandom_range(long_hold, 1));
            endcase
        end
        hold_for(16'h0000, long_hold);
        end_test("random");
    endtask

    always @(posedge clk) begin
        if (rst_n && event_valid) begin
            if (exp_q.size() == 0) begin
                stop_with_failure($sformatf("unexpected %s of %s with no event left to expect",
                                            event_data.kind.name(), event_data.code.name()));
            end else begin
                compare_event(exp_test.pop_front(), exp_q.pop_front(), event_data);
            end
        end
    end

    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        stop_with_failure("watchdog timeout: the expected events did not arrive in time");
    end

    initial begin
        int longest;
        int chk_errors;
        void'($urandom(32'he574));
        rst_n    <= 1'b0;
        key_mask <= 16'h0000;
        build_all_keys();
        build_bounce();
        build_two_keys();
        build_slide();
        build_random(40);
        longest = 0;
        foreach (step_hold[i]) begin
            if (step_hold[i] > longest) begin
                longest = step_hold[i];
            end
        end
        watchdog_ns = (step_mask.size() * longest + 10) * scan_interval * clk_period;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        // line up with a frame start, then change keys halfway between frames
        do begin
            @(posedge clk);
        end while (col_out != 4'b1110);
        repeat (scan_interval / 2) @(posedge clk);
        foreach (step_mask[i]) begin
            key_mask <= step_mask[i];
            repeat (step_hold[i] * scan_interval) @(posedge clk);
        end
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // a stray event would show up within these frames
        repeat (2 * scan_interval) @(posedge clk);
        chk_errors = i_dut.i_scanner.i_scan_chk.error_count +
                     i_dut.i_event_gen.i_evt_chk.error_count;
        if (chk_errors == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            stop_with_failure($sformatf("%0d assertion failures in the bound checkers",
                                        chk_errors));
        end
    end

endmodule
